// ==== source/soc_pkg.sv ====
// word-only bus, 32-bit addresses; targets decoded by mask, timer registers are word offsets
package soc_pkg;

	// --------------------------------------------------
	// bus and timer types

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [63:0] timer_count_t;

	// wait means a request is on the bus and its response is due
	typedef enum logic {
		ARB_IDLE,
		ARB_WAIT
	} arb_state_t;

	// --------------------------------------------------
	// address map

	localparam bus_addr_t SRAM_BASE   = 32'h0000_0000;
	localparam bus_addr_t TIMER_BASE  = 32'h4000_0000;
	localparam bus_addr_t DECODE_MASK = 32'he000_c000;

	// timer register offsets
	localparam bus_addr_t TMR_CTRL      = 32'h0000_0000;
	localparam bus_addr_t TMR_MTIME     = 32'h0000_0008;
	localparam bus_addr_t TMR_MTIMEH    = 32'h0000_000c;
	localparam bus_addr_t TMR_MTIMECMP  = 32'h0000_0010;
	localparam bus_addr_t TMR_MTIMECMPH = 32'h0000_0014;

	// control register bits
	localparam int CTRL_EN_BIT       = 0;
	localparam int CTRL_DBG_STOP_BIT = 1;

endpackage

// ==== source/bus_arbiter.sv ====
// two masters, one transaction in flight; a waiting master must hold vld until its rdy pulse
`timescale 1ns/10ps

module bus_arbiter import soc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      cpu_vld,
	input  logic      cpu_write,
	input  bus_addr_t cpu_addr,
	input  bus_data_t cpu_wdata,
	output logic      cpu_rdy,
	output logic      cpu_err,
	output bus_data_t cpu_rdata,

	input  logic      dbg_vld,
	input  logic      dbg_write,
	input  bus_addr_t dbg_addr,
	input  bus_data_t dbg_wdata,
	output logic      dbg_rdy,
	output logic      dbg_err,
	output bus_data_t dbg_rdata,

	output logic      bus_req,
	output logic      bus_write,
	output bus_addr_t bus_addr,
	output bus_data_t bus_wdata,
	input  logic      bus_ack,
	input  logic      bus_err,
	input  bus_data_t bus_rdata
);

	arb_state_t state;
	// high when dbg holds the grant, or was served last while idle
	logic last_dbg;
	logic pick_dbg;
	logic launch;
	logic resp;

	assign resp = (state == ARB_WAIT) && bus_ack;

	// prefer the master not served last
	assign pick_dbg = dbg_vld && (!cpu_vld || !last_dbg);

	always_comb begin
		case (state)
			ARB_IDLE: launch = cpu_vld || dbg_vld;
			// other master may start right behind the response
			ARB_WAIT: launch = bus_ack && (last_dbg ? cpu_vld : dbg_vld);
			default:  launch = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ARB_IDLE;
			last_dbg <= 1'b1;
			bus_req  <= 1'b0;
		end else begin
			bus_req <= launch;
			if (launch) begin
				state    <= ARB_WAIT;
				last_dbg <= pick_dbg;
			end else if (resp) begin
				state <= ARB_IDLE;
			end
		end
	end

	// request payload, captured with the strobe
	always_ff @(posedge clk) begin
		if (launch) begin
			bus_write <= pick_dbg ? dbg_write : cpu_write;
			bus_addr  <= pick_dbg ? dbg_addr : cpu_addr;
			bus_wdata <= pick_dbg ? dbg_wdata : cpu_wdata;
		end
	end

	// --------------------------------------------------
	// response routing

	assign cpu_rdy   = resp && !last_dbg;
	assign dbg_rdy   = resp && last_dbg;
	assign cpu_err   = cpu_rdy && bus_err;
	assign dbg_err   = dbg_rdy && bus_err;
	assign cpu_rdata = cpu_rdy ? bus_rdata : '0;
	assign dbg_rdata = dbg_rdy ? bus_rdata : '0;

endmodule

// ==== source/addr_decoder.sv ====
// sram window limited to SRAM_DEPTH words; any other address answers with err and zero data
`timescale 1ns/10ps

module addr_decoder import soc_pkg::*; #(
	parameter int SRAM_DEPTH = 1024
) (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      bus_req,
	input  logic      bus_write,
	input  bus_addr_t bus_addr,
	input  bus_data_t bus_wdata,
	output logic      bus_ack,
	output logic      bus_err,
	output bus_data_t bus_rdata,

	output logic      sram_sel,
	output logic      tmr_sel,
	output logic      tgt_write,
	output bus_addr_t tgt_addr,
	output bus_data_t tgt_wdata,
	input  bus_data_t sram_rdata,
	input  bus_data_t tmr_rdata
);

	bus_addr_t region;
	logic      sram_hit;
	logic      tmr_hit;
	// target selected in the request cycle
	logic      sram_q;
	logic      tmr_q;

	assign region   = bus_addr & DECODE_MASK;
	assign sram_hit = (region == SRAM_BASE) && ((bus_addr >> 2) < bus_addr_t'(SRAM_DEPTH));
	assign tmr_hit  = (region == TIMER_BASE);

	assign sram_sel  = bus_req && sram_hit;
	assign tmr_sel   = bus_req && tmr_hit;
	assign tgt_write = bus_write;
	assign tgt_addr  = bus_addr;
	assign tgt_wdata = bus_wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_ack <= 1'b0;
			bus_err <= 1'b0;
			sram_q  <= 1'b0;
			tmr_q   <= 1'b0;
		end else begin
			bus_ack <= bus_req;
			bus_err <= bus_req && !(sram_hit || tmr_hit);
			sram_q  <= sram_sel;
			tmr_q   <= tmr_sel;
		end
	end

	// zero when unmapped
	always_comb begin
		if (sram_q)
			bus_rdata = sram_rdata;
		else if (tmr_q)
			bus_rdata = tmr_rdata;
		else
			bus_rdata = '0;
	end

endmodule

// ==== source/sram_store.sv ====
// SRAM_DEPTH must be a power of two, at least 2; contents are undefined after power-up
`timescale 1ns/10ps

module sram_store import soc_pkg::*; #(
	parameter int SRAM_DEPTH = 1024
) (
	input  logic      clk,
	input  logic      sel,
	input  logic      write,
	input  bus_addr_t addr,
	input  bus_data_t wdata,
	output bus_data_t rdata
);

	localparam int AW = $clog2(SRAM_DEPTH);

	bus_data_t      mem [SRAM_DEPTH];
	logic [AW-1:0]  idx;

	// byte lanes ignored, upper bits wrap
	assign idx = addr[AW+1:2];

	// read-before-write, so a write returns the old word
	always_ff @(posedge clk) begin
		if (sel) begin
			if (write) begin
				mem[idx] <= wdata;
			end
			rdata <= mem[idx];
		end
	end

endmodule

// ==== source/machine_timer.sv ====
// tick every CLK_MHZ cycles; halves of mtime are written separately, with no carry protection
`timescale 1ns/10ps

module machine_timer import soc_pkg::*; #(
	parameter int CLK_MHZ = 27
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      sel,
	input  logic      write,
	input  bus_addr_t addr,
	input  bus_data_t wdata,
	output bus_data_t rdata,
	input  logic      dbg_halt,
	output logic      irq
);

	localparam int        TICK_W   = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;
	localparam bus_addr_t OFF_MASK = 32'h0000_3ffc;

	logic [TICK_W-1:0] tick_ctr;
	logic              tick;
	logic [1:0]        ctrl;
	timer_count_t      mtime;
	timer_count_t      mtimecmp;
	timer_count_t      mtime_nxt;
	bus_addr_t         reg_off;
	bus_data_t         rd_word;
	logic              wr;
	logic              count_en;

	// --------------------------------------------------
	// microsecond prescaler

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
			tick     <= 1'b0;
		end else begin
			if (|tick_ctr)
				tick_ctr <= tick_ctr - 1'b1;
			else
				tick_ctr <= TICK_W'(CLK_MHZ - 1);
			tick <= ~|tick_ctr;
		end
	end

	// --------------------------------------------------
	// registers

	assign reg_off  = addr & OFF_MASK;
	assign wr       = sel && write;
	assign count_en = ctrl[CTRL_EN_BIT] && !(dbg_halt && ctrl[CTRL_DBG_STOP_BIT]);

	// bus write wins over the tick for the half it touches
	always_comb begin
		mtime_nxt = mtime + timer_count_t'(tick && count_en);
		if (wr && reg_off == TMR_MTIME)
			mtime_nxt[31:0] = wdata;
		if (wr && reg_off == TMR_MTIMEH)
			mtime_nxt[63:32] = wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl     <= 2'b01;
			mtime    <= '0;
			mtimecmp <= '1;
			irq      <= 1'b0;
		end else begin
			mtime <= mtime_nxt;
			if (wr && reg_off == TMR_CTRL)
				ctrl <= wdata[1:0];
			if (wr && reg_off == TMR_MTIMECMP)
				mtimecmp[31:0] <= wdata;
			if (wr && reg_off == TMR_MTIMECMPH)
				mtimecmp[63:32] <= wdata;
			irq <= (mtime >= mtimecmp);
		end
	end

	// unknown offsets read zero
	always_comb begin
		case (reg_off)
			TMR_CTRL:      rd_word = bus_data_t'(ctrl);
			TMR_MTIME:     rd_word = mtime[31:0];
			TMR_MTIMEH:    rd_word = mtime[63:32];
			TMR_MTIMECMP:  rd_word = mtimecmp[31:0];
			TMR_MTIMECMPH: rd_word = mtimecmp[63:32];
			default:       rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (sel)
			rdata <= rd_word;
	end

endmodule

// ==== source/soc_bus_top.sv ====
// two external masters share sram and timer; word accesses only, response 2 cycles after vld
`timescale 1ns/10ps

module soc_bus_top import soc_pkg::*; #(
	parameter int SRAM_DEPTH = 1024,
	parameter int CLK_MHZ    = 27
) (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      cpu_vld,
	input  logic      cpu_write,
	input  bus_addr_t cpu_addr,
	input  bus_data_t cpu_wdata,
	output logic      cpu_rdy,
	output logic      cpu_err,
	output bus_data_t cpu_rdata,

	input  logic      dbg_vld,
	input  logic      dbg_write,
	input  bus_addr_t dbg_addr,
	input  bus_data_t dbg_wdata,
	output logic      dbg_rdy,
	output logic      dbg_err,
	output bus_data_t dbg_rdata,

	input  logic      dbg_halt,
	output logic      timer_irq
);

	// --------------------------------------------------
	// shared bus and target wires

	logic      bus_req;
	logic      bus_write;
	bus_addr_t bus_addr;
	bus_data_t bus_wdata;
	logic      bus_ack;
	logic      bus_err;
	bus_data_t bus_rdata;

	logic      sram_sel;
	logic      tmr_sel;
	logic      tgt_write;
	bus_addr_t tgt_addr;
	bus_data_t tgt_wdata;
	bus_data_t sram_rdata;
	bus_data_t tmr_rdata;

	bus_arbiter u_bus_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_vld   (cpu_vld),
		.cpu_write (cpu_write),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdy   (cpu_rdy),
		.cpu_err   (cpu_err),
		.cpu_rdata (cpu_rdata),
		.dbg_vld   (dbg_vld),
		.dbg_write (dbg_write),
		.dbg_addr  (dbg_addr),
		.dbg_wdata (dbg_wdata),
		.dbg_rdy   (dbg_rdy),
		.dbg_err   (dbg_err),
		.dbg_rdata (dbg_rdata),
		.bus_req   (bus_req),
		.bus_write (bus_write),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ack   (bus_ack),
		.bus_err   (bus_err),
		.bus_rdata (bus_rdata)
	);

	addr_decoder #(
		.SRAM_DEPTH (SRAM_DEPTH)
	) u_addr_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.bus_req    (bus_req),
		.bus_write  (bus_write),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_ack    (bus_ack),
		.bus_err    (bus_err),
		.bus_rdata  (bus_rdata),
		.sram_sel   (sram_sel),
		.tmr_sel    (tmr_sel),
		.tgt_write  (tgt_write),
		.tgt_addr   (tgt_addr),
		.tgt_wdata  (tgt_wdata),
		.sram_rdata (sram_rdata),
		.tmr_rdata  (tmr_rdata)
	);

	sram_store #(
		.SRAM_DEPTH (SRAM_DEPTH)
	) u_sram_store (
		.clk   (clk),
		.sel   (sram_sel),
		.write (tgt_write),
		.addr  (tgt_addr),
		.wdata (tgt_wdata),
		.rdata (sram_rdata)
	);

	machine_timer #(
		.CLK_MHZ (CLK_MHZ)
	) u_machine_timer (
		.clk      (clk),
		.rst_n    (rst_n),
		.sel      (tmr_sel),
		.write    (tgt_write),
		.addr     (tgt_addr),
		.wdata    (tgt_wdata),
		.rdata    (tmr_rdata),
		.dbg_halt (dbg_halt),
		.irq      (timer_irq)
	);

endmodule

// ==== include/tb_lfsr.svh ====
// include inside a module scope; the caller keeps the state and steps it once per random bit
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// --------------------------------------------------
// 32-bit galois lfsr, x^32 + x^22 + x^2 + x + 1

localparam logic [31:0] TB_LFSR_SEED = 32'h0fa9_356d;
localparam logic [31:0] TB_LFSR_TAPS = 32'h8020_0003;

// one step; the bit shifted out is the random bit
function automatic logic [31:0] tb_lfsr_next(input logic [31:0] state);
	logic [31:0] nxt;
	nxt = state >> 1;
	if (state[0])
		nxt = nxt ^ TB_LFSR_TAPS;
	return nxt;
endfunction

`endif

// ==== verification/tb_soc_bus.sv ====
// timer bounds assume a 4-cycle tick and a 256-word sram, both fixed at the DUT instance
`timescale 1ns/10ps

module tb_soc_bus import soc_pkg::*; ();

	localparam int SRAM_WORDS   = 256;
	localparam int WORD_BITS    = $clog2(SRAM_WORDS);
	localparam int TICK_CYCLES  = 4;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int RAND_OPS     = 300;
	localparam int CONT_ROUNDS  = 24;
	localparam int OP_COUNT     = SRAM_WORDS + RAND_OPS + 3 * CONT_ROUNDS + 64;
	localparam int OP_BOUND     = 8;
	localparam int IDLE_BUDGET  = 400;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + OP_COUNT * OP_BOUND + IDLE_BUDGET) * CLK_PERIOD;

	`include "tb_lfsr.svh"

	logic      clk;
	logic      rst_n;
	logic      cpu_vld;
	logic      cpu_write;
	bus_addr_t cpu_addr;
	bus_data_t cpu_wdata;
	logic      cpu_rdy;
	logic      cpu_err;
	bus_data_t cpu_rdata;
	logic      dbg_vld;
	logic      dbg_write;
	bus_addr_t dbg_addr;
	bus_data_t dbg_wdata;
	logic      dbg_rdy;
	logic      dbg_err;
	bus_data_t dbg_rdata;
	logic      dbg_halt;
	logic      timer_irq;

	bus_data_t   model_mem [SRAM_WORDS];
	logic [31:0] lfsr_state;
	// arbiter preference model, dbg served last after reset
	logic        model_last_dbg;
	int          errors;
	int          checks;
	int          cyc = 0;
	bus_data_t   rd_cpu;
	bus_data_t   rd_dbg;
	logic        er_cpu;
	logic        er_dbg;
	int          lat_cpu;
	int          lat_dbg;

	soc_bus_top #(
		.SRAM_DEPTH (SRAM_WORDS),
		.CLK_MHZ    (TICK_CYCLES)
	) u_soc_bus_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_vld   (cpu_vld),
		.cpu_write (cpu_write),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdy   (cpu_rdy),
		.cpu_err   (cpu_err),
		.cpu_rdata (cpu_rdata),
		.dbg_vld   (dbg_vld),
		.dbg_write (dbg_write),
		.dbg_addr  (dbg_addr),
		.dbg_wdata (dbg_wdata),
		.dbg_rdy   (dbg_rdy),
		.dbg_err   (dbg_err),
		.dbg_rdata (dbg_rdata),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// --------------------------------------------------
	// helpers

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = tb_lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic bus_data_t fill_word(input bus_addr_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// one request on a master port, latency counted in edges until rdy
	task automatic bus_access(input logic on_dbg, input logic wr, input bus_addr_t addr,
			input bus_data_t wdata, output bus_data_t rdata, output logic err, output int lat);
		logic done;
		done = 1'b0;
		lat = 0;
		@(posedge clk);
		if (on_dbg) begin
			dbg_vld   <= 1'b1;
			dbg_write <= wr;
			dbg_addr  <= addr;
			dbg_wdata <= wdata;
		end else begin
			cpu_vld   <= 1'b1;
			cpu_write <= wr;
			cpu_addr  <= addr;
			cpu_wdata <= wdata;
		end
		while (!done) begin
			@(negedge clk);
			if (on_dbg ? dbg_rdy : cpu_rdy) begin
				done  = 1'b1;
				rdata = on_dbg ? dbg_rdata : cpu_rdata;
				err   = on_dbg ? dbg_err : cpu_err;
			end else begin
				lat++;
			end
		end
		@(posedge clk);
		if (on_dbg)
			dbg_vld <= 1'b0;
		else
			cpu_vld <= 1'b0;
	endtask

	task automatic access_checked(input logic on_dbg, input logic wr, input bus_addr_t addr,
			input bus_data_t wdata, input logic exp_err, input string name,
			output bus_data_t rdata);
		logic err;
		int   lat;
		bus_access(on_dbg, wr, addr, wdata, rdata, err, lat);
		check({name, " latency"}, 2, lat);
		check({name, " err"}, exp_err, err);
		model_last_dbg = on_dbg;
	endtask

	// a write answers with the old word
	task automatic sram_op(input logic on_dbg, input logic wr, input int word,
			input bus_data_t wdata);
		bus_data_t rdata;
		access_checked(on_dbg, wr, bus_addr_t'(word) << 2, wdata, 1'b0, "sram", rdata);
		check("sram rdata", model_mem[word], rdata);
		if (wr)
			model_mem[word] = wdata;
	endtask

	task automatic tmr_write(input bus_addr_t off, input bus_data_t data);
		bus_data_t rdata;
		access_checked(1'b0, 1'b1, TIMER_BASE | off, data, 1'b0, "timer write", rdata);
	endtask

	task automatic tmr_read(input bus_addr_t off, output bus_data_t data);
		access_checked(1'b1, 1'b0, TIMER_BASE | off, '0, 1'b0, "timer read", data);
	endtask

	// --------------------------------------------------
	// watchdog

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
		$display("Regression failed");
		$finish;
	end

	// --------------------------------------------------
	// main sequence

	initial begin
		logic      port;
		logic      wr;
		logic      win_dbg;
		int        word;
		int        cw;
		int        dw;
		int        n_wait;
		int        t_wr;
		int        lo;
		int        hi;
		bus_data_t wd;
		bus_data_t v0;
		bus_data_t v1;
		bus_data_t cmp;
		bus_data_t exp_cpu;
		bus_data_t exp_dbg;

		rst_n     <= 1'b0;
		cpu_vld   <= 1'b0;
		cpu_write <= 1'b0;
		cpu_addr  <= '0;
		cpu_wdata <= '0;
		dbg_vld   <= 1'b0;
		dbg_write <= 1'b0;
		dbg_addr  <= '0;
		dbg_wdata <= '0;
		dbg_halt  <= 1'b0;
		lfsr_state     = TB_LFSR_SEED;
		model_last_dbg = 1'b1;
		errors         = 0;
		checks         = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// fill from alternating ports, then random traffic
		for (int i = 0; i < SRAM_WORDS; i++)
			sram_op(1'(i), 1'b1, i, fill_word(bus_addr_t'(i) << 2));
		for (int i = 0; i < RAND_OPS; i++) begin
			port = 1'(take_bits(1));
			wr   = 1'(take_bits(1));
			word = int'(take_bits(WORD_BITS));
			wd   = take_bits(32);
			sram_op(port, wr, word, wd);
		end

		// same-cycle requests, cpu writes while dbg reads
		for (int r = 0; r < CONT_ROUNDS; r++) begin
			if (take_bits(1) != 0)
				sram_op(1'(take_bits(1)), 1'b0, int'(take_bits(WORD_BITS)), '0);
			cw      = int'(take_bits(WORD_BITS));
			dw      = int'(take_bits(WORD_BITS));
			wd      = take_bits(32);
			win_dbg = !model_last_dbg;
			exp_cpu = model_mem[cw];
			if (win_dbg)
				exp_dbg = model_mem[dw];
			model_mem[cw] = wd;
			if (!win_dbg)
				exp_dbg = model_mem[dw];
			fork
				bus_access(1'b0, 1'b1, bus_addr_t'(cw) << 2, wd, rd_cpu, er_cpu, lat_cpu);
				bus_access(1'b1, 1'b0, bus_addr_t'(dw) << 2, '0, rd_dbg, er_dbg, lat_dbg);
			join
			check("contention cpu rdata", exp_cpu, rd_cpu);
			check("contention dbg rdata", exp_dbg, rd_dbg);
			check("contention cpu latency", win_dbg ? 4 : 2, lat_cpu);
			check("contention dbg latency", win_dbg ? 2 : 4, lat_dbg);
			check("contention err", 0, {er_cpu, er_dbg});
			model_last_dbg = !win_dbg;
		end

		// unmapped, and words past the depth that would wrap onto 0 and 1
		access_checked(1'b0, 1'b1, 32'h8000_0000, 32'hdead_beef, 1'b1, "unmapped write", v0);
		check("unmapped write rdata", 0, v0);
		access_checked(1'b1, 1'b0, 32'h8000_0000, '0, 1'b1, "unmapped read", v0);
		check("unmapped read rdata", 0, v0);
		access_checked(1'b1, 1'b1, SRAM_WORDS * 4, 32'h1234_5678, 1'b1, "beyond depth", v0);
		check("beyond depth rdata", 0, v0);
		access_checked(1'b0, 1'b1, SRAM_WORDS * 4 + 4, 32'h8765_4321, 1'b1,
				"beyond depth wrap", v0);
		check("beyond depth wrap rdata", 0, v0);
		sram_op(1'b0, 1'b0, 0, '0);
		sram_op(1'b1, 1'b0, 1, '0);

		// tick rate
		tmr_write(TMR_MTIMEH, '0);
		tmr_write(TMR_MTIME, '0);
		t_wr   = cyc;
		n_wait = 20 + int'(take_bits(6));
		repeat (n_wait) @(posedge clk);
		tmr_read(TMR_MTIME, v0);
		n_wait = cyc - t_wr;
		lo     = n_wait / TICK_CYCLES - 1;
		hi     = (n_wait + TICK_CYCLES - 1) / TICK_CYCLES + 1;
		checks++;
		if (int'(v0) < lo || int'(v0) > hi) begin
			errors++;
			$display("ERR tick rate expected %0d to %0d actual %0d after %0d cycles",
					lo, hi, v0, n_wait);
		end

		// compare interrupt
		tmr_read(TMR_MTIME, v0);
		cmp = v0 + 3;
		tmr_write(TMR_MTIMECMPH, '0);
		tmr_write(TMR_MTIMECMP, cmp);
		repeat ((3 + 2) * TICK_CYCLES + 2) @(posedge clk);
		@(negedge clk);
		check("irq raised", 1, timer_irq);
		tmr_read(TMR_MTIME, v1);
		checks++;
		if (v1 < cmp) begin
			errors++;
			$display("ERR mtime at irq expected at least %0h actual %0h", cmp, v1);
		end
		tmr_write(TMR_MTIMECMPH, '1);
		tmr_write(TMR_MTIMECMP, '1);
		repeat (2) @(negedge clk);
		check("irq cleared", 0, timer_irq);

		// freeze by debug halt, then by enable
		@(posedge clk);
		dbg_halt <= 1'b1;
		tmr_write(TMR_CTRL, (1 << CTRL_EN_BIT) | (1 << CTRL_DBG_STOP_BIT));
		tmr_read(TMR_CTRL, v0);
		check("ctrl readback", 3, v0);
		tmr_read(TMR_MTIME, v0);
		repeat (5 * TICK_CYCLES) @(posedge clk);
		tmr_read(TMR_MTIME, v1);
		check("mtime halted", v0, v1);
		@(posedge clk);
		dbg_halt <= 1'b0;
		tmr_write(TMR_CTRL, '0);
		tmr_read(TMR_MTIME, v0);
		repeat (5 * TICK_CYCLES) @(posedge clk);
		tmr_read(TMR_MTIME, v1);
		check("mtime disabled", v0, v1);
		tmr_write(TMR_CTRL, 1 << CTRL_EN_BIT);
		repeat (5 * TICK_CYCLES) @(posedge clk);
		tmr_read(TMR_MTIME, v0);
		checks++;
		if (v0 <= v1) begin
			errors++;
			$display("ERR mtime advance expected above %0h actual %0h", v1, v0);
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
source/soc_pkg.sv
source/bus_arbiter.sv
source/addr_decoder.sv
source/sram_store.sv
source/machine_timer.sv
source/soc_bus_top.sv
verification/tb_soc_bus.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - files:
      - source/soc_pkg.sv
      - source/bus_arbiter.sv
      - source/addr_decoder.sv
      - source/sram_store.sv
      - source/machine_timer.sv
      - source/soc_bus_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_soc_bus.sv
